//--- include/ht_defines.svh
// ~~~~~~~~~~~~~~~~~~~~
// Widths of the hash table. Only the values below are supported.
// HT_PTR_W sets the slot count and HT_BUCKET_W the bucket count.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef HT_DEFINES_SVH
`define HT_DEFINES_SVH

`define HT_KEY_W     16  // Key width.
`define HT_VALUE_W   16  // Value width.
`define HT_PTR_W     4   // 16 entry slots.
`define HT_BUCKET_W  3   // 8 buckets.
`define HT_CMD_Q_AW  3   // Command queue holds 8 commands.

`endif

//--- design/ht_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Data types of the hash table.
// Widths come from the defines header.
// ~~~~~~~~~~~~~~~~~~~~
`include "ht_defines.svh"

package ht_pkg;

  // Payload carried by a command.
  typedef logic [`HT_KEY_W-1:0]    key_t;
  typedef logic [`HT_VALUE_W-1:0]  value_t;

  // Entry slot address.
  typedef logic [`HT_PTR_W-1:0]    ptr_t;

  // Bucket index, the output of the hash.
  typedef logic [`HT_BUCKET_W-1:0] bucket_t;

endpackage

//--- design/ht_cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command opcodes, result statuses and engine states.
// Encodings are fixed; the golden file depends on them.
// ~~~~~~~~~~~~~~~~~~~~
package ht_cmd_pkg;

  typedef enum logic [1:0] {
    OP_INSERT = 2'd0,
    OP_SEARCH = 2'd1,
    OP_DELETE = 2'd2
  } opcode_e;

  typedef enum logic [2:0] {
    ST_INSERTED   = 3'd0,
    ST_UPDATED    = 3'd1,
    ST_FOUND      = 3'd2,
    ST_NOT_FOUND  = 3'd3,
    ST_DELETED    = 3'd4,
    ST_TABLE_FULL = 3'd5
  } status_e;

  // Chain-walking engine FSM.
  typedef enum logic [2:0] {
    IDLE,
    WALK,
    INSERT_NEW,
    UNLINK,
    RESPOND
  } eng_state_e;

endpackage

//--- design/ht_scfifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Single-clock FIFO with show-ahead output.
// A write when full and a read when empty are ignored.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ht_scfifo #(
  parameter int DATA_W = 8,
  parameter int ADDR_W = 3
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              wr_req_i,
  input  logic              rd_req_i,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              empty_o,
  output logic              full_o
);

  localparam int DEPTH = 2**ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   cnt;     // One bit wider, so full and empty differ.
  logic              wr_en;
  logic              rd_en;

  assign wr_en = wr_req_i && !full_o;
  assign rd_en = rd_req_i && !empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en)
        cnt <= cnt + 1'b1;
      else if (rd_en && !wr_en)
        cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_data_i;
  end

  assign rd_data_o = mem[rd_ptr];  // Head word is always on the output.
  assign empty_o   = (cnt == '0);
  assign full_o    = (cnt == DEPTH[ADDR_W:0]);

endmodule

//--- design/ht_empty_ptr_storage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Pool of free slot pointers.
// Loads every slot address after reset; ready_o rises after 16 cycles.
// Returns must not arrive before ready_o.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "ht_defines.svh"

module ht_empty_ptr_storage (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  ht_pkg::ptr_t  add_ptr_i,
  input  logic          add_ptr_en_i,
  input  logic          next_ptr_rd_ack_i,
  output ht_pkg::ptr_t  next_ptr_o,
  output logic          next_ptr_val_o,
  output logic          ready_o
);

  ht_pkg::ptr_t init_cnt;
  ht_pkg::ptr_t wr_ptr;
  logic         wr_req;
  logic         fifo_empty;

  // ~~~~~~~~~~~~~~~~~~~~
  // Init sequence.
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      init_cnt <= '0;
      ready_o  <= 1'b0;
    end
    else if (!ready_o)
    begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == '1)
        ready_o <= 1'b1;  // Last address written this cycle.
    end
  end

  // Init counter owns the write port until ready.
  assign wr_ptr = ready_o ? add_ptr_i : init_cnt;
  assign wr_req = ready_o ? add_ptr_en_i : 1'b1;

  ht_scfifo #(
    .DATA_W  ( `HT_PTR_W ),
    .ADDR_W  ( `HT_PTR_W )
  ) ptr_fifo (
    .clk_i      ( clk_i             ),
    .arst_n_i   ( arst_n_i          ),
    .wr_data_i  ( wr_ptr            ),
    .wr_req_i   ( wr_req            ),
    .rd_req_i   ( next_ptr_rd_ack_i ),
    .rd_data_o  ( next_ptr_o        ),
    .empty_o    ( fifo_empty        ),
    .full_o     (                   )
  );

  assign next_ptr_val_o = !fifo_empty;  // Empty pool means a full table.

endmodule

//--- design/ht_hash_calc.sv
// ~~~~~~~~~~~~~~~~~~~~
// Hash stage. Bucket is the XOR of 3-bit key slices from the LSB.
// Output follows the command by exactly one cycle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "ht_defines.svh"

module ht_hash_calc (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  ht_cmd_pkg::opcode_e  cmd_op_i,
  input  ht_pkg::key_t         cmd_key_i,
  input  ht_pkg::value_t       cmd_value_i,
  output logic                 hc_valid_o,
  output ht_cmd_pkg::opcode_e  hc_op_o,
  output ht_pkg::bucket_t      hc_bucket_o,
  output ht_pkg::key_t         hc_key_o,
  output ht_pkg::value_t       hc_value_o
);

  ht_pkg::bucket_t bucket;

  // Key bit i lands on bucket bit i mod 3, which is the slice fold.
  always_comb
  begin
    bucket = '0;
    for (int i = 0; i < `HT_KEY_W; i++)
      bucket[i % `HT_BUCKET_W] = bucket[i % `HT_BUCKET_W] ^ cmd_key_i[i];
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      hc_valid_o <= 1'b0;
    else
      hc_valid_o <= cmd_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    hc_op_o     <= cmd_op_i;
    hc_bucket_o <= bucket;
    hc_key_o    <= cmd_key_i;
    hc_value_o  <= cmd_value_i;
  end

endmodule

//--- design/ht_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// Chain-walking engine. Serves one command at a time from the queue.
// New entries go to the chain head. Commands wait for ptr_ready_i.
// Results are non-zero in value only for a found search.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "ht_defines.svh"

module ht_engine (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 q_empty_i,
  input  ht_cmd_pkg::opcode_e  q_op_i,
  input  ht_pkg::bucket_t      q_bucket_i,
  input  ht_pkg::key_t         q_key_i,
  input  ht_pkg::value_t       q_value_i,
  output logic                 q_rd_ack_o,
  input  logic                 ptr_ready_i,
  input  ht_pkg::ptr_t         next_ptr_i,
  input  logic                 next_ptr_val_i,
  output logic                 next_ptr_rd_ack_o,
  output ht_pkg::ptr_t         add_ptr_o,
  output logic                 add_ptr_en_o,
  output logic                 res_valid_o,
  output ht_cmd_pkg::status_e  res_status_o,
  output ht_pkg::value_t       res_value_o
);

  localparam int NUM_BUCKETS = 2**`HT_BUCKET_W;
  localparam int NUM_SLOTS   = 2**`HT_PTR_W;

  ht_cmd_pkg::eng_state_e state;

  // Head table.
  logic [NUM_BUCKETS-1:0] head_val;
  ht_pkg::ptr_t           head_ptr [NUM_BUCKETS];

  // Entry memory.
  ht_pkg::key_t   ent_key      [NUM_SLOTS];
  ht_pkg::value_t ent_value    [NUM_SLOTS];
  ht_pkg::ptr_t   ent_next     [NUM_SLOTS];
  logic           ent_next_val [NUM_SLOTS];

  // Command in service and walk position.
  ht_cmd_pkg::opcode_e op_q;
  ht_pkg::bucket_t     bucket_q;
  ht_pkg::key_t        key_q;
  ht_pkg::value_t      value_q;
  ht_pkg::ptr_t        cur_ptr;
  logic                cur_val;
  ht_pkg::ptr_t        prev_ptr;
  logic                prev_val;  // Low while cur_ptr is the chain head.
  ht_cmd_pkg::status_e status_q;
  ht_pkg::value_t      res_value_q;

  logic accept;
  logic key_hit;

  assign accept  = (state == ht_cmd_pkg::IDLE) && !q_empty_i && ptr_ready_i;
  assign key_hit = cur_val && (ent_key[cur_ptr] == key_q);

  // ~~~~~~~~~~~~~~~~~~~~
  // FSM and head valid bits.
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state    <= ht_cmd_pkg::IDLE;
      head_val <= '0;
    end
    else
    begin
      case (state)
        ht_cmd_pkg::IDLE:
          if (accept)
            state <= ht_cmd_pkg::WALK;
        ht_cmd_pkg::WALK:
          if (!cur_val)  // End of chain, key absent.
          begin
            if (op_q == ht_cmd_pkg::OP_INSERT && next_ptr_val_i)
              state <= ht_cmd_pkg::INSERT_NEW;
            else
              state <= ht_cmd_pkg::RESPOND;
          end
          else if (key_hit)
          begin
            if (op_q == ht_cmd_pkg::OP_DELETE)
              state <= ht_cmd_pkg::UNLINK;
            else
              state <= ht_cmd_pkg::RESPOND;
          end
        ht_cmd_pkg::INSERT_NEW:
        begin
          head_val[bucket_q] <= 1'b1;
          state              <= ht_cmd_pkg::RESPOND;
        end
        ht_cmd_pkg::UNLINK:
        begin
          if (!prev_val)
            head_val[bucket_q] <= ent_next_val[cur_ptr];  // Chain may go empty.
          state <= ht_cmd_pkg::RESPOND;
        end
        default:
          state <= ht_cmd_pkg::IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Walk registers and table memories.
  always_ff @(posedge clk_i)
  begin
    case (state)
      ht_cmd_pkg::IDLE:
        if (accept)
        begin
          op_q        <= q_op_i;
          bucket_q    <= q_bucket_i;
          key_q       <= q_key_i;
          value_q     <= q_value_i;
          cur_ptr     <= head_ptr[q_bucket_i];
          cur_val     <= head_val[q_bucket_i];
          prev_val    <= 1'b0;
          res_value_q <= '0;
        end
      ht_cmd_pkg::WALK:
        if (!cur_val)
        begin
          if (op_q != ht_cmd_pkg::OP_INSERT)
            status_q <= ht_cmd_pkg::ST_NOT_FOUND;
          else if (next_ptr_val_i)
            status_q <= ht_cmd_pkg::ST_INSERTED;
          else
            status_q <= ht_cmd_pkg::ST_TABLE_FULL;
        end
        else if (key_hit)
        begin
          case (op_q)
            ht_cmd_pkg::OP_INSERT:
            begin
              ent_value[cur_ptr] <= value_q;  // Overwrite in place.
              status_q           <= ht_cmd_pkg::ST_UPDATED;
            end
            ht_cmd_pkg::OP_SEARCH:
            begin
              res_value_q <= ent_value[cur_ptr];
              status_q    <= ht_cmd_pkg::ST_FOUND;
            end
            default:
              status_q <= ht_cmd_pkg::ST_DELETED;
          endcase
        end
        else
        begin
          prev_ptr <= cur_ptr;
          prev_val <= 1'b1;
          cur_ptr  <= ent_next[cur_ptr];
          cur_val  <= ent_next_val[cur_ptr];
        end
      ht_cmd_pkg::INSERT_NEW:
      begin
        // Link the fresh slot in front of the old head.
        ent_key[next_ptr_i]      <= key_q;
        ent_value[next_ptr_i]    <= value_q;
        ent_next[next_ptr_i]     <= head_ptr[bucket_q];
        ent_next_val[next_ptr_i] <= head_val[bucket_q];
        head_ptr[bucket_q]       <= next_ptr_i;
      end
      ht_cmd_pkg::UNLINK:
        if (prev_val)
        begin
          ent_next[prev_ptr]     <= ent_next[cur_ptr];
          ent_next_val[prev_ptr] <= ent_next_val[cur_ptr];
        end
        else
          head_ptr[bucket_q] <= ent_next[cur_ptr];
      default:
      begin
      end
    endcase
  end

  assign q_rd_ack_o        = accept;
  assign next_ptr_rd_ack_o = (state == ht_cmd_pkg::INSERT_NEW);
  assign add_ptr_o         = cur_ptr;  // Slot being unlinked.
  assign add_ptr_en_o      = (state == ht_cmd_pkg::UNLINK);
  assign res_valid_o       = (state == ht_cmd_pkg::RESPOND);
  assign res_status_o      = status_q;
  assign res_value_o       = res_value_q;

endmodule

//--- design/ht_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Hash table top level. Wait for ready_o before sending commands.
// At most 8 commands may be outstanding; extra ones are lost.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "ht_defines.svh"

module ht_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  ht_cmd_pkg::opcode_e  cmd_op_i,
  input  ht_pkg::key_t         cmd_key_i,
  input  ht_pkg::value_t       cmd_value_i,
  output logic                 res_valid_o,
  output ht_cmd_pkg::status_e  res_status_o,
  output ht_pkg::value_t       res_value_o,
  output logic                 ready_o
);

  localparam int OP_W  = $bits(ht_cmd_pkg::opcode_e);
  localparam int CMD_W = OP_W + `HT_BUCKET_W + `HT_KEY_W + `HT_VALUE_W;

  // Queue word is {op, bucket, key, value}, value in the LSBs.
  localparam int KEY_LSB    = `HT_VALUE_W;
  localparam int BUCKET_LSB = KEY_LSB + `HT_KEY_W;
  localparam int OP_LSB     = BUCKET_LSB + `HT_BUCKET_W;

  logic                hc_valid;
  ht_cmd_pkg::opcode_e hc_op;
  ht_pkg::bucket_t     hc_bucket;
  ht_pkg::key_t        hc_key;
  ht_pkg::value_t      hc_value;
  logic [CMD_W-1:0]    q_wr_data;
  logic [CMD_W-1:0]    q_rd_data;
  logic                q_empty;
  logic                q_rd_ack;
  ht_cmd_pkg::opcode_e q_op;
  ht_pkg::ptr_t        next_ptr;
  logic                next_ptr_val;
  logic                next_ptr_rd_ack;
  ht_pkg::ptr_t        add_ptr;
  logic                add_ptr_en;

  ht_hash_calc hash_calc (
    .clk_i        ( clk_i       ),
    .arst_n_i     ( arst_n_i    ),
    .cmd_valid_i  ( cmd_valid_i ),
    .cmd_op_i     ( cmd_op_i    ),
    .cmd_key_i    ( cmd_key_i   ),
    .cmd_value_i  ( cmd_value_i ),
    .hc_valid_o   ( hc_valid    ),
    .hc_op_o      ( hc_op       ),
    .hc_bucket_o  ( hc_bucket   ),
    .hc_key_o     ( hc_key      ),
    .hc_value_o   ( hc_value    )
  );

  assign q_wr_data = {hc_op, hc_bucket, hc_key, hc_value};

  ht_scfifo #(
    .DATA_W  ( CMD_W        ),
    .ADDR_W  ( `HT_CMD_Q_AW )
  ) cmd_queue (
    .clk_i      ( clk_i     ),
    .arst_n_i   ( arst_n_i  ),
    .wr_data_i  ( q_wr_data ),
    .wr_req_i   ( hc_valid  ),
    .rd_req_i   ( q_rd_ack  ),
    .rd_data_o  ( q_rd_data ),
    .empty_o    ( q_empty   ),
    .full_o     (           )
  );

  assign q_op = ht_cmd_pkg::opcode_e'(q_rd_data[OP_LSB +: OP_W]);

  ht_empty_ptr_storage ptr_storage (
    .clk_i              ( clk_i           ),
    .arst_n_i           ( arst_n_i        ),
    .add_ptr_i          ( add_ptr         ),
    .add_ptr_en_i       ( add_ptr_en      ),
    .next_ptr_rd_ack_i  ( next_ptr_rd_ack ),
    .next_ptr_o         ( next_ptr        ),
    .next_ptr_val_o     ( next_ptr_val    ),
    .ready_o            ( ready_o         )
  );

  ht_engine engine (
    .clk_i              ( clk_i                                      ),
    .arst_n_i           ( arst_n_i                                   ),
    .q_empty_i          ( q_empty                                    ),
    .q_op_i             ( q_op                                       ),
    .q_bucket_i         ( q_rd_data[BUCKET_LSB +: `HT_BUCKET_W]      ),
    .q_key_i            ( q_rd_data[KEY_LSB +: `HT_KEY_W]            ),
    .q_value_i          ( q_rd_data[0 +: `HT_VALUE_W]                ),
    .q_rd_ack_o         ( q_rd_ack                                   ),
    .ptr_ready_i        ( ready_o                                    ),
    .next_ptr_i         ( next_ptr                                   ),
    .next_ptr_val_i     ( next_ptr_val                               ),
    .next_ptr_rd_ack_o  ( next_ptr_rd_ack                            ),
    .add_ptr_o          ( add_ptr                                    ),
    .add_ptr_en_o       ( add_ptr_en                                 ),
    .res_valid_o        ( res_valid_o                                ),
    .res_status_o       ( res_status_o                               ),
    .res_value_o        ( res_value_o                                )
  );

endmodule

//--- test/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock with a 10 ns period.
// Active-low reset is held for 5 rising edges.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 5;

  initial
  begin
    clk_o = 1'b0;
    forever
      #HALF_PERIOD clk_o = ~clk_o;
  end

  initial
  begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES)
      @(posedge clk_o);
    #1 arst_n_o = 1'b1;  // Release away from the clock edge.
  end

endmodule

//--- test/tb_ht_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the hash table top level.
// Reads test/ht_golden.txt, so the simulator must run in the project root.
// Groups hold at most 8 commands, the depth of the command queue.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_ht_top;

  localparam int MAX_GROUP    = 8;
  localparam int READY_LIMIT  = 100;  // Cycles for the pointer pool to fill.
  localparam int READY_CYCLES = 16;   // One slot address loaded per cycle.
  localparam int RESULT_LIMIT = 200;  // Cycles allowed per result.

  logic                clk;
  logic                arst_n;
  logic                cmd_valid;
  ht_cmd_pkg::opcode_e cmd_op;
  ht_pkg::key_t        cmd_key;
  ht_pkg::value_t      cmd_value;
  logic                res_valid;
  ht_cmd_pkg::status_e res_status;
  ht_pkg::value_t      res_value;
  logic                ready;

  logic [2:0]      got_status [$];  // Results in arrival order.
  ht_pkg::value_t  got_value  [$];

  // Current group from the golden file.
  logic [8*32-1:0] grp_name;
  int              grp_size;
  int              grp_op        [MAX_GROUP];
  int              grp_key       [MAX_GROUP];
  int              grp_value     [MAX_GROUP];
  int              grp_status    [MAX_GROUP];
  int              grp_exp_value [MAX_GROUP];

  int fd;
  int tests_run;
  int tests_failed;
  int checks_run;
  int mismatches;
  int other_errors;

  tb_clock_gen clock_gen (
    .clk_o     ( clk    ),
    .arst_n_o  ( arst_n )
  );

  ht_top ht_top_inst (
    .clk_i         ( clk        ),
    .arst_n_i      ( arst_n     ),
    .cmd_valid_i   ( cmd_valid  ),
    .cmd_op_i      ( cmd_op     ),
    .cmd_key_i     ( cmd_key    ),
    .cmd_value_i   ( cmd_value  ),
    .res_valid_o   ( res_valid  ),
    .res_status_o  ( res_status ),
    .res_value_o   ( res_value  ),
    .ready_o       ( ready      )
  );

  // Result strobes are sampled in the middle of the cycle.
  always @(negedge clk)
  begin
    if (res_valid === 1'b1)
    begin
      got_status.push_back(res_status);
      got_value.push_back(res_value);
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks_run++;
    if (actual !== expected)
    begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Golden file access.
  task automatic read_record(input int idx, output bit found);
    logic [8*128-1:0] line;
    logic [8*32-1:0]  name;
    int               size;
    int               op;
    int               key;
    int               value;
    int               status;
    int               exp_val;
    int               n;
    found = 1'b0;
    while (!found && !$feof(fd))
    begin
      line = '0;
      n    = $fgets(line, fd);
      if (n > 0)
      begin
        n = $sscanf(line, "%s %d %h %h %h %h %h",
                    name, size, op, key, value, status, exp_val);
        if (n == 7)  // Comment and blank lines fail the scan.
        begin
          found              = 1'b1;
          grp_op[idx]        = op;
          grp_key[idx]       = key;
          grp_value[idx]     = value;
          grp_status[idx]    = status;
          grp_exp_value[idx] = exp_val;
          if (idx == 0)
          begin
            grp_name = name;
            grp_size = size;
          end
        end
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus and result collection.
  task automatic send_group();
    for (int i = 0; i < grp_size; i++)
    begin
      @(posedge clk);
      #1;
      cmd_valid = 1'b1;
      cmd_op    = ht_cmd_pkg::opcode_e'(grp_op[i][1:0]);
      cmd_key   = grp_key[i][15:0];
      cmd_value = grp_value[i][15:0];
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic collect_group(output bit timed_out);
    int wait_cycles;
    timed_out = 1'b0;
    for (int i = 0; i < grp_size && !timed_out; i++)
    begin
      wait_cycles = 0;
      while (got_status.size() == 0 && wait_cycles < RESULT_LIMIT)
      begin
        @(posedge clk);
        wait_cycles++;
      end
      if (got_status.size() == 0)
      begin
        timed_out = 1'b1;
        other_errors++;
        $display("Timeout at %0t ns: no result for command %0d of test %0s within %0d cycles",
                 $time, i, grp_name, RESULT_LIMIT);
      end
      else
      begin
        check_value("res_status_o", got_status.pop_front(), grp_status[i]);
        check_value("res_value_o", got_value.pop_front(), grp_exp_value[i]);
      end
    end
  endtask

  initial
  begin
    bit ok;
    bit done;
    bit aborted;
    int wait_cycles;
    int errors_before;
    cmd_valid    = 1'b0;
    cmd_op       = ht_cmd_pkg::OP_SEARCH;
    cmd_key      = '0;
    cmd_value    = '0;
    tests_run    = 0;
    tests_failed = 0;
    checks_run   = 0;
    mismatches   = 0;
    other_errors = 0;
    done         = 1'b0;
    aborted      = 1'b0;

    fd = $fopen("test/ht_golden.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open test/ht_golden.txt for reading");
      other_errors++;
      aborted = 1'b1;
    end

    if (!aborted)
    begin
      wait_cycles = 0;
      while (arst_n !== 1'b1 && wait_cycles < READY_LIMIT)
      begin
        @(negedge clk);
        wait_cycles++;
      end
      // Count rising edges from reset release until the pool is full.
      wait_cycles = 0;
      while (ready !== 1'b1 && wait_cycles < READY_LIMIT)
      begin
        @(posedge clk);
        #1;
        wait_cycles++;
      end
      if (ready !== 1'b1)
      begin
        $display("Timeout: ready_o stayed low for %0d cycles after reset release",
                 READY_LIMIT);
        other_errors++;
        aborted = 1'b1;
      end
      else
      begin
        errors_before = mismatches;
        check_value("ready_o latency", wait_cycles, READY_CYCLES);
        tests_run++;
        if (mismatches != errors_before)
        begin
          tests_failed++;
          $display("Test pool_init, 1 check: FAIL");
        end
        else
          $display("Test pool_init, 1 check: PASS");
      end
    end

    while (!aborted && !done)
    begin
      read_record(0, ok);
      if (!ok)
        done = 1'b1;
      else if (grp_size < 1 || grp_size > MAX_GROUP)
      begin
        $display("Group size %0d of test %0s is out of range", grp_size, grp_name);
        other_errors++;
        aborted = 1'b1;
      end
      else
      begin
        for (int i = 1; i < grp_size && ok; i++)
          read_record(i, ok);
        if (!ok)
        begin
          $display("Golden file ends inside test %0s", grp_name);
          other_errors++;
          aborted = 1'b1;
        end
        else
        begin
          errors_before = mismatches + other_errors;
          if (got_status.size() != 0)
          begin
            $display("Unexpected result strobe before test %0s", grp_name);
            other_errors++;
            got_status.delete();
            got_value.delete();
          end
          send_group();
          collect_group(aborted);
          tests_run++;
          if (mismatches + other_errors != errors_before)
          begin
            tests_failed++;
            $display("Test %0s, %0d commands: FAIL", grp_name, grp_size);
          end
          else
            $display("Test %0s, %0d commands: PASS", grp_name, grp_size);
        end
      end
    end

    if (fd != 0)
      $fclose(fd);
    $display("Summary: %0d tests, %0d failing, %0d checks, %0d mismatches, %0d other errors",
             tests_run, tests_failed, checks_run, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0 && tests_run > 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
design/ht_pkg.sv
design/ht_cmd_pkg.sv
design/ht_scfifo.sv
design/ht_empty_ptr_storage.sv
design/ht_hash_calc.sv
design/ht_engine.sv
design/ht_top.sv
test/tb_clock_gen.sv
test/tb_ht_top.sv

//--- test/ht_golden.txt
# name group op key value status exp_value; group is decimal, the rest hex
# op 0 ins 1 srch 2 del; status 0 ins 1 upd 2 found 3 not_found 4 del 5 full
ins_srch 8 0 0001 1111 0 0000
ins_srch 8 0 0002 2222 0 0000
ins_srch 8 0 0004 4444 0 0000
ins_srch 8 0 0008 8888 0 0000
ins_srch 8 1 0001 0000 2 1111
ins_srch 8 1 0002 0000 2 2222
ins_srch 8 1 0004 0000 2 4444
ins_srch 8 1 0008 0000 2 8888
update 2 0 0002 2a2a 1 0000
update 2 1 0002 0000 2 2a2a
chain_del 8 0 0040 4040 0 0000
chain_del 8 2 0040 0000 4 0000
chain_del 8 2 0040 0000 3 0000
chain_del 8 0 0040 4040 0 0000
chain_del 8 2 0008 0000 4 0000
chain_del 8 2 0001 0000 4 0000
chain_del 8 1 0040 0000 2 4040
chain_del 8 1 0008 0000 3 0000
absent 2 1 0000 0000 3 0000
absent 2 1 0200 0000 3 0000
fill_a 8 0 1000 a000 0 0000
fill_a 8 0 1001 a001 0 0000
fill_a 8 0 1002 a002 0 0000
fill_a 8 0 1003 a003 0 0000
fill_a 8 0 1004 a004 0 0000
fill_a 8 0 1005 a005 0 0000
fill_a 8 0 1006 a006 0 0000
fill_a 8 0 1007 a007 0 0000
fill_b 8 0 1008 a008 0 0000
fill_b 8 0 1009 a009 0 0000
fill_b 8 0 100a a00a 0 0000
fill_b 8 0 100b a00b 0 0000
fill_b 8 0 100c a00c 0 0000
fill_b 8 0 100d a00d 5 0000
fill_b 8 2 1003 0000 4 0000
fill_b 8 0 100e a00e 0 0000
